// ==== rtl/warp_pkg.sv ====
`default_nettype none

package warp_pkg;

    localparam int NUM_WARPS  = 8;
    localparam int WARP_IDX_W = $clog2(NUM_WARPS);

    typedef logic [NUM_WARPS-1:0]  warp_mask_t;  // One bit per warp
    typedef logic [WARP_IDX_W-1:0] warp_idx_t;

endpackage

`default_nettype wire

// ==== rtl/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    localparam int STARVE_CNT_W = 4;

    // Which picker supplied the issued warp
    typedef enum logic {
        CLASS_LO = 1'b0,
        CLASS_HI = 1'b1
    } issue_class_e;

    typedef logic [STARVE_CNT_W-1:0] starve_cnt_t;  // Consecutive high issues

endpackage

`default_nettype wire

// ==== rtl/onehot_encoder.sv ====
`default_nettype none

module onehot_encoder #(
    parameter int  N       = 8,
    parameter int  REVERSE = 0,
    parameter int  MODEL   = 1,
    localparam int LN      = (N > 1) ? $clog2(N) : 1
) (
    input  wire  [N-1:0]  data_in,
    output logic [LN-1:0] data_out,
    output logic          valid_out
);

    if (MODEL == 1) begin : g_tree
        localparam int M = 1 << LN;

        logic [LN:0][M-1:0]         v;
        logic [LN:0][M-1:0][LN-1:0] addr;

        // Pad to a power of two, reversed inputs sit at the top
        assign v[0]    = (REVERSE != 0) ? (M'(data_in) << (M - N)) : M'(data_in);
        assign addr[0] = '0;

        for (genvar lvl = 1; lvl <= LN; lvl++) begin : g_lvl
            for (genvar s = 0; s < M; s++) begin : g_node
                if (s < (M >> lvl)) begin : g_used
                    logic lo;
                    logic hi;
                    logic sel;

                    assign lo  = v[lvl-1][2*s];
                    assign hi  = v[lvl-1][2*s+1];
                    assign sel = (REVERSE != 0) ? lo : hi;  // Address bit for this level

                    assign v[lvl][s]    = lo | hi;
                    assign addr[lvl][s] = (LN'(sel) << (lvl - 1))
                                        | addr[lvl-1][2*s]
                                        | addr[lvl-1][2*s+1];
                end else begin : g_pad
                    assign v[lvl][s]    = 1'b0;
                    assign addr[lvl][s] = '0;
                end
            end
        end

        assign data_out  = addr[LN][0];
        assign valid_out = v[LN][0];

    end else begin : g_loop
        logic [LN-1:0] idx;

        always_comb begin
            idx = '0;
            for (int i = 0; i < N; i++) begin
                if (data_in[i]) begin
                    idx = (REVERSE != 0) ? LN'(N - 1 - i) : LN'(i);
                end
            end
        end

        assign data_out  = idx;
        assign valid_out = |data_in;
    end

endmodule

`default_nettype wire

// ==== rtl/rr_picker.sv ====
`default_nettype none

module rr_picker
    import warp_pkg::*;
#(
    parameter int N        = NUM_WARPS,
    parameter int HI_CLASS = 1
) (
    input  wire             clk,
    input  wire             rst,
    input  wire warp_mask_t ready_mask,
    input  wire warp_mask_t hi_mask,
    input  wire             take,
    output logic            pick_valid,
    output warp_idx_t       pick_idx
);

    logic [N-1:0] req;
    logic [N-1:0] upto_ptr;
    logic [N-1:0] req_above;
    logic [N-1:0] search;
    logic [N-1:0] grant;
    warp_idx_t    ptr;

    // Request set of the class this picker serves
    assign req = (HI_CLASS != 0) ? (ready_mask & hi_mask) : (ready_mask & ~hi_mask);

    // Ones at the pointer and below, all ones when the pointer is at the top
    assign upto_ptr  = ((N'(1) << ptr) << 1) - N'(1);
    assign req_above = req & ~upto_ptr;

    assign search = (|req_above) ? req_above : req;  // Wrap around when nothing is above
    assign grant  = search & (~search + N'(1));       // Lowest set bit

    onehot_encoder #(
        .N       (N),
        .REVERSE (0),
        .MODEL   (1)
    ) u_enc (
        .data_in   (grant),
        .data_out  (pick_idx),
        .valid_out (pick_valid)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= warp_idx_t'(N - 1);  // Warp 0 goes first
        end else if (take) begin
            ptr <= pick_idx;
        end
    end

    // The merge may only take a pick that is valid in the same cycle
    take_needs_pick : assert property (
        @(posedge clk) disable iff (rst)
        take |-> pick_valid
    ) else $error("rr_picker: take without a valid pick");

endmodule

`default_nettype wire

// ==== rtl/issue_merge.sv ====
`default_nettype none

module issue_merge
    import warp_pkg::*;
    import issue_pkg::*;
#(
    parameter int STARVE_LIMIT = 3
) (
    input  wire            clk,
    input  wire            rst,
    input  wire            stall,
    input  wire            hi_valid,
    input  wire warp_idx_t hi_idx,
    input  wire            lo_valid,
    input  wire warp_idx_t lo_idx,
    output logic           hi_take,
    output logic           lo_take,
    output logic           issue_valid,
    output warp_idx_t      issue_warp,
    output logic           issue_hi
);

    starve_cnt_t  starve_cnt;
    issue_class_e win_class;
    issue_class_e issue_class;
    logic         starved;
    logic         issue_now;

    // A waiting normal warp wins once the high class has used up its run
    assign starved   = lo_valid && (starve_cnt >= starve_cnt_t'(STARVE_LIMIT));
    assign win_class = (hi_valid && !starved) ? CLASS_HI : CLASS_LO;
    assign issue_now = !stall && (hi_valid || lo_valid);

    assign hi_take = issue_now && (win_class == CLASS_HI);
    assign lo_take = issue_now && (win_class == CLASS_LO);

    always_ff @(posedge clk) begin
        if (rst) begin
            starve_cnt <= '0;
        end else if (!stall) begin
            if (!lo_valid || lo_take) begin
                starve_cnt <= '0;  // Nobody is starving
            end else if (hi_take) begin
                starve_cnt <= starve_cnt + starve_cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
            issue_class <= CLASS_LO;
        end else begin
            issue_valid <= issue_now;
            issue_class <= issue_now ? win_class : CLASS_LO;
        end
    end

    always_ff @(posedge clk) begin
        issue_warp <= (win_class == CLASS_HI) ? hi_idx : lo_idx;
    end

    assign issue_hi = (issue_class == CLASS_HI);

    cnt_bound : assert property (
        @(posedge clk) disable iff (rst)
        starve_cnt <= starve_cnt_t'(STARVE_LIMIT)
    ) else $error("issue_merge: starvation count above limit");

endmodule

`default_nettype wire

// ==== rtl/warp_sched.sv ====
`default_nettype none

module warp_sched
    import warp_pkg::*;
#(
    parameter int N            = NUM_WARPS,
    parameter int STARVE_LIMIT = 3
) (
    input  wire             clk,
    input  wire             rst,
    input  wire warp_mask_t ready_mask,
    input  wire warp_mask_t hi_mask,
    input  wire             stall,
    output logic            issue_valid,
    output warp_idx_t       issue_warp,
    output logic            issue_hi
);

    logic      hi_valid;
    logic      lo_valid;
    logic      hi_take;
    logic      lo_take;
    warp_idx_t hi_idx;
    warp_idx_t lo_idx;

    rr_picker #(
        .N        (N),
        .HI_CLASS (1)
    ) pick_hi (
        .clk        (clk),
        .rst        (rst),
        .ready_mask (ready_mask),
        .hi_mask    (hi_mask),
        .take       (hi_take),
        .pick_valid (hi_valid),
        .pick_idx   (hi_idx)
    );

    rr_picker #(
        .N        (N),
        .HI_CLASS (0)
    ) pick_lo (
        .clk        (clk),
        .rst        (rst),
        .ready_mask (ready_mask),
        .hi_mask    (hi_mask),
        .take       (lo_take),
        .pick_valid (lo_valid),
        .pick_idx   (lo_idx)
    );

    issue_merge #(
        .STARVE_LIMIT (STARVE_LIMIT)
    ) u_merge (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .hi_valid    (hi_valid),
        .hi_idx      (hi_idx),
        .lo_valid    (lo_valid),
        .lo_idx      (lo_idx),
        .hi_take     (hi_take),
        .lo_take     (lo_take),
        .issue_valid (issue_valid),
        .issue_warp  (issue_warp),
        .issue_hi    (issue_hi)
    );

endmodule

`default_nettype wire

// ==== testbench/warp_sched_checker.sv ====
`default_nettype none

module warp_sched_checker
    import warp_pkg::*;
    import issue_pkg::*;
#(
    parameter int STARVE_LIMIT = 3
) (
    input  wire             clk,
    input  wire             rst,
    input  wire warp_mask_t ready_mask,
    input  wire warp_mask_t hi_mask,
    input  wire             stall,
    input  wire [2:0]       phase,
    input  wire             done,
    input  wire             issue_valid,
    input  wire warp_idx_t  issue_warp,
    input  wire             issue_hi,
    output int              err_count
);

    warp_idx_t    hi_ptr;
    warp_idx_t    lo_ptr;
    starve_cnt_t  cnt;
    logic         have_pred;
    logic         exp_valid;
    warp_idx_t    exp_warp;
    issue_class_e exp_class;
    logic         exp_stall;
    logic [2:0]   exp_phase;
    int           check_count;
    int           hi_run;
    logic         last_lo;

    initial begin
        have_pred   = 1'b0;
        err_count   = 0;
        check_count = 0;
        hi_run      = 0;
        last_lo     = 1'b0;
    end

    function automatic string phase_name(input logic [2:0] p);
        case (p)
            3'd1:    return "rr_fair";
            3'd2:    return "hi_first";
            3'd3:    return "starve_guard";
            3'd4:    return "stall_hold";
            3'd5:    return "idle_reset";
            default: return "reset";
        endcase
    endfunction

    // Lowest request above the pointer, else the lowest request overall
    function automatic logic next_warp(input warp_mask_t req, input warp_idx_t ptr,
                                       output warp_idx_t idx);
        logic found;
        found = 1'b0;
        idx   = '0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            if (!found && req[i] && (i > int'(ptr))) begin
                found = 1'b1;
                idx   = warp_idx_t'(i);
            end
        end
        for (int i = 0; i < NUM_WARPS; i++) begin
            if (!found && req[i]) begin
                found = 1'b1;
                idx   = warp_idx_t'(i);
            end
        end
        return found;
    endfunction

    // Inputs are stable at the rising edge, so the prediction for the next outputs is made here
    always @(posedge clk) begin
        logic      hv;
        logic      lv;
        warp_idx_t hi_idx;
        warp_idx_t lo_idx;
        hv = next_warp(ready_mask & hi_mask, hi_ptr, hi_idx);
        lv = next_warp(ready_mask & ~hi_mask, lo_ptr, lo_idx);
        if (rst) begin
            hi_ptr    = warp_idx_t'(NUM_WARPS - 1);
            lo_ptr    = warp_idx_t'(NUM_WARPS - 1);
            cnt       = '0;
            exp_valid = 1'b0;
        end else if (stall || !(hv || lv)) begin
            exp_valid = 1'b0;
            if (!stall) begin
                cnt = '0;
            end
        end else if (hv && !(lv && int'(cnt) >= STARVE_LIMIT)) begin
            exp_valid = 1'b1;
            exp_class = CLASS_HI;
            exp_warp  = hi_idx;
            hi_ptr    = hi_idx;
            cnt       = lv ? cnt + starve_cnt_t'(1) : '0;  // Counts only while a normal warp waits
        end else begin
            exp_valid = 1'b1;
            exp_class = CLASS_LO;
            exp_warp  = lo_idx;
            lo_ptr    = lo_idx;
            cnt       = '0;
        end
        exp_stall = stall && !rst;
        exp_phase = phase;
        have_pred = 1'b1;
    end

    always @(negedge clk) begin
        if (have_pred) begin
            check_count++;
            if (issue_valid !== exp_valid) begin
                $display("ERR %s issue_valid expected %0b actual %0b",
                         phase_name(exp_phase), exp_valid, issue_valid);
                err_count++;
            end else if (exp_valid) begin
                if (issue_warp !== exp_warp) begin
                    $display("ERR %s issue_warp expected %0d actual %0d",
                             phase_name(exp_phase), exp_warp, issue_warp);
                    err_count++;
                end
                if (issue_hi !== (exp_class == CLASS_HI)) begin
                    $display("ERR %s issue_hi expected %0b actual %0b",
                             phase_name(exp_phase), exp_class == CLASS_HI, issue_hi);
                    err_count++;
                end
            end
            if (exp_stall && issue_valid === 1'b1) begin
                $display("%s: a warp issued right after a stall cycle", phase_name(exp_phase));
                err_count++;
            end
            if (exp_phase != 3'd3) begin
                hi_run  = 0;
                last_lo = 1'b0;
            end else if (issue_valid === 1'b1) begin
                if (issue_hi === 1'b1) begin
                    hi_run++;
                    if (hi_run > STARVE_LIMIT) begin
                        $display("starve_guard: %0d high issues in a row while normal warps waited",
                                 hi_run);
                        err_count++;
                    end
                end else begin
                    if (last_lo) begin
                        $display("starve_guard: two normal issues in a row with high warps ready");
                        err_count++;
                    end
                    hi_run = 0;
                end
                last_lo = (issue_hi !== 1'b1);
            end
        end
    end

    always @(posedge done) begin
        $display("checks: %0d  errors: %0d", check_count, err_count);
    end

endmodule

`default_nettype wire

// ==== testbench/warp_sched_tb.sv ====
`default_nettype none

module warp_sched_tb
    import warp_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int STARVE_LIMIT  = 3;
    localparam int RESET_CYCLES  = 2;
    localparam int PHASE_CYCLES  = 200;
    localparam int NUM_PHASES    = 5;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + NUM_PHASES * PHASE_CYCLES + 2;
    localparam int WATCHDOG_TIME = (TOTAL_CYCLES + 50) * CLK_PERIOD;

    logic       clk;
    logic       rst;
    logic       stall;
    logic       done;
    logic [2:0] phase;
    warp_mask_t ready_mask;
    warp_mask_t hi_mask;
    logic       issue_valid;
    logic       issue_hi;
    warp_idx_t  issue_warp;
    int         err_count;
    integer     seed;

    warp_sched #(
        .N            (NUM_WARPS),
        .STARVE_LIMIT (STARVE_LIMIT)
    ) warp_sched_i (
        .clk         (clk),
        .rst         (rst),
        .ready_mask  (ready_mask),
        .hi_mask     (hi_mask),
        .stall       (stall),
        .issue_valid (issue_valid),
        .issue_warp  (issue_warp),
        .issue_hi    (issue_hi)
    );

    warp_sched_checker #(
        .STARVE_LIMIT (STARVE_LIMIT)
    ) u_checker (
        .clk         (clk),
        .rst         (rst),
        .ready_mask  (ready_mask),
        .hi_mask     (hi_mask),
        .stall       (stall),
        .phase       (phase),
        .done        (done),
        .issue_valid (issue_valid),
        .issue_warp  (issue_warp),
        .issue_hi    (issue_hi),
        .err_count   (err_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Sets the inputs for one cycle of the given phase
    task automatic drive_cycle(input int p, input int c);
        int r;
        r          = $random(seed);
        phase      = 3'(p);
        rst        = 1'b0;
        stall      = 1'b0;
        hi_mask    = warp_mask_t'($random(seed));
        ready_mask = warp_mask_t'($random(seed));
        case (p)
            1: hi_mask = '0;
            2: ready_mask = hi_mask;  // Only high warps are ready
            3: begin
                ready_mask = '1;
                hi_mask    = {(NUM_WARPS / 2){2'b10}};  // Odd warps are high priority
            end
            4: stall = r[0];
            5: begin
                stall      = r[0];
                ready_mask = '0;
                rst        = (c == PHASE_CYCLES / 2) || (c == PHASE_CYCLES / 2 + 1);
                if (c >= PHASE_CYCLES - 10) begin
                    ready_mask = '1;  // First grants after the reset pulse
                    stall      = 1'b0;
                end
            end
            default: ready_mask = '0;
        endcase
    endtask

    initial begin
        seed       = 32'h1467;
        rst        = 1'b1;
        stall      = 1'b0;
        done       = 1'b0;
        phase      = 3'd0;
        ready_mask = '0;
        hi_mask    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        for (int p = 1; p <= NUM_PHASES; p++) begin
            for (int c = 0; c < PHASE_CYCLES; c++) begin
                drive_cycle(p, c);
                @(negedge clk);
            end
        end
        drive_cycle(0, 0);
        @(negedge clk);
        #10;
        done = 1'b1;
        #1;
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before the stimulus finished");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/warp_pkg.sv
rtl/issue_pkg.sv
rtl/onehot_encoder.sv
rtl/rr_picker.sv
rtl/issue_merge.sv
rtl/warp_sched.sv
testbench/warp_sched_checker.sv
testbench/warp_sched_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the warp scheduler testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module warp_sched_tb -f sim.f -o warp_sched_sim \
    && ./obj_dir/warp_sched_sim | tee /dev/stderr | grep -qxF '>>> PASS' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
